/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_rca_lsq
FILELIST ?= rca_lsq.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rca_lsq.f */
rtl/rca_lsq_pkg.sv
rtl/toggle_memory.sv
rtl/id_fifo.sv
rtl/packet_store.sv
rtl/request_selector.sv
rtl/rca_lsq.sv
testbench/tb_rca_lsq.sv

/* rtl/id_fifo.sv */
module id_fifo (
    input logic clk,
    input logic arst_n,
    input logic push,
    input logic pop,
    input rca_lsq_pkg::id_t data_in,
    output rca_lsq_pkg::id_t data_out,
    output logic valid,
    output logic full
);
    import rca_lsq_pkg::*;

    id_t id_mem [MAX_IDS];
    id_t rd_ptr;
    id_t wr_ptr;
    logic [ID_W:0] count;

    // Id storage
    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at MAX_IDS
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    assign data_out = id_mem[rd_ptr];
    assign valid = (count != '0);
    assign full = (count == (ID_W + 1)'(MAX_IDS));

endmodule

/* rtl/packet_store.sv */
module packet_store (
    input logic clk,
    input logic wr_en,
    input rca_lsq_pkg::id_t wr_id,
    input rca_lsq_pkg::id_t rd_id,
    input logic [rca_lsq_pkg::XLEN-1:0] row_addr_in [rca_lsq_pkg::GRID_NUM_ROWS],
    input logic [rca_lsq_pkg::XLEN-1:0] row_data_in [rca_lsq_pkg::GRID_NUM_ROWS],
    input logic [rca_lsq_pkg::FN3_W-1:0] row_fn3_in [rca_lsq_pkg::GRID_NUM_ROWS],
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_load_in,
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_store_in,
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_valid_in,
    output logic [rca_lsq_pkg::XLEN-1:0] row_addr_out [rca_lsq_pkg::GRID_NUM_ROWS],
    output logic [rca_lsq_pkg::XLEN-1:0] row_data_out [rca_lsq_pkg::GRID_NUM_ROWS],
    output logic [rca_lsq_pkg::FN3_W-1:0] row_fn3_out [rca_lsq_pkg::GRID_NUM_ROWS],
    output logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_load_out,
    output logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_store_out,
    output logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_valid_out
);
    import rca_lsq_pkg::*;

    logic [XLEN-1:0] addr_mem [MAX_IDS][GRID_NUM_ROWS];
    logic [XLEN-1:0] data_mem [MAX_IDS][GRID_NUM_ROWS];
    logic [FN3_W-1:0] fn3_mem [MAX_IDS][GRID_NUM_ROWS];
    logic [GRID_NUM_ROWS-1:0] load_mem [MAX_IDS];
    logic [GRID_NUM_ROWS-1:0] store_mem [MAX_IDS];
    logic [GRID_NUM_ROWS-1:0] valid_mem [MAX_IDS]; // Row request bits

    // Whole packet written at capture
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < GRID_NUM_ROWS; i++) begin
                addr_mem[wr_id][i] <= row_addr_in[i];
                data_mem[wr_id][i] <= row_data_in[i];
                fn3_mem[wr_id][i] <= row_fn3_in[i];
            end
            load_mem[wr_id] <= row_load_in;
            store_mem[wr_id] <= row_store_in;
            valid_mem[wr_id] <= row_valid_in;
        end
    end

    always_comb begin
        for (int i = 0; i < GRID_NUM_ROWS; i++) begin
            row_addr_out[i] = addr_mem[rd_id][i];
            row_data_out[i] = data_mem[rd_id][i];
            row_fn3_out[i] = fn3_mem[rd_id][i];
        end
    end

    assign row_load_out = load_mem[rd_id];
    assign row_store_out = store_mem[rd_id];
    assign row_valid_out = valid_mem[rd_id];

endmodule

/* rtl/rca_lsq.sv */
module rca_lsq (
    input logic clk,
    input logic arst_n,
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] new_request,
    input logic [rca_lsq_pkg::XLEN-1:0] addr [rca_lsq_pkg::GRID_NUM_ROWS],
    input logic [rca_lsq_pkg::XLEN-1:0] data [rca_lsq_pkg::GRID_NUM_ROWS],
    input logic [rca_lsq_pkg::FN3_W-1:0] fn3 [rca_lsq_pkg::GRID_NUM_ROWS],
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] load,
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] store,
    output logic fifo_full,
    output logic lsu_new_request,
    output logic [rca_lsq_pkg::XLEN-1:0] lsu_addr,
    output logic [rca_lsq_pkg::XLEN-1:0] lsu_data,
    output logic [rca_lsq_pkg::FN3_W-1:0] lsu_fn3,
    output logic lsu_load,
    output logic lsu_store,
    output logic lsu_lock,
    input logic credit_return
);
    import rca_lsq_pkg::*;

    id_t next_id;
    id_t head_id;
    logic pushed_bit;
    logic popped_bit;
    logic capture;
    logic fifo_valid;
    logic packet_done;
    logic [ROW_W-1:0] next_row;

    logic [XLEN-1:0] head_addr [GRID_NUM_ROWS];
    logic [XLEN-1:0] head_data [GRID_NUM_ROWS];
    logic [FN3_W-1:0] head_fn3 [GRID_NUM_ROWS];
    logic [GRID_NUM_ROWS-1:0] head_load;
    logic [GRID_NUM_ROWS-1:0] head_store;
    logic [GRID_NUM_ROWS-1:0] head_valid_rows;

    // Empty packets are never captured
    assign capture = (pushed_bit == popped_bit) && (|new_request);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_id <= '0;
        end else if (capture) begin
            next_id <= next_id + 1'b1;
        end
    end

    toggle_memory id_pushed (
        .clk(clk),
        .arst_n(arst_n),
        .toggle(capture),
        .toggle_id(next_id),
        .read_id(next_id),
        .read_data(pushed_bit)
    );

    toggle_memory id_popped (
        .clk(clk),
        .arst_n(arst_n),
        .toggle(packet_done),
        .toggle_id(head_id),
        .read_id(next_id),
        .read_data(popped_bit)
    );

    id_fifo packet_ids (
        .clk(clk),
        .arst_n(arst_n),
        .push(capture),
        .pop(packet_done),
        .data_in(next_id),
        .data_out(head_id),
        .valid(fifo_valid),
        .full(fifo_full)
    );

    packet_store packets (
        .clk(clk),
        .wr_en(capture),
        .wr_id(next_id),
        .rd_id(head_id),
        .row_addr_in(addr),
        .row_data_in(data),
        .row_fn3_in(fn3),
        .row_load_in(load),
        .row_store_in(store),
        .row_valid_in(new_request),
        .row_addr_out(head_addr),
        .row_data_out(head_data),
        .row_fn3_out(head_fn3),
        .row_load_out(head_load),
        .row_store_out(head_store),
        .row_valid_out(head_valid_rows)
    );

    request_selector selector (
        .clk(clk),
        .arst_n(arst_n),
        .head_valid(fifo_valid),
        .row_valid(head_valid_rows),
        .credit_return(credit_return),
        .next_row(next_row),
        .issue(lsu_new_request),
        .packet_done(packet_done)
    );

    // Selected row toward the LSU
    assign lsu_addr = head_addr[next_row];
    assign lsu_data = head_data[next_row];
    assign lsu_fn3 = head_fn3[next_row];
    assign lsu_load = head_load[next_row];
    assign lsu_store = head_store[next_row];

    assign lsu_lock = fifo_valid; // Any packet in flight

endmodule

/* rtl/rca_lsq_pkg.sv */
package rca_lsq_pkg;

    // Array geometry
    localparam int GRID_NUM_ROWS = 4;
    localparam int ROW_W = $clog2(GRID_NUM_ROWS);

    // Request fields
    localparam int XLEN = 32;
    localparam int FN3_W = 3;

    // Packet ids, also the id FIFO depth
    // MAX_IDS must be a power of two so pointers wrap on their own
    localparam int MAX_IDS = 4;
    localparam int ID_W = $clog2(MAX_IDS);

    typedef logic [ID_W-1:0] id_t;

    // Credits toward the load/store unit
    localparam int LSU_CREDITS = 2;
    localparam int CREDIT_W = $clog2(LSU_CREDITS + 1);

endpackage

/* rtl/request_selector.sv */
module request_selector (
    input logic clk,
    input logic arst_n,
    input logic head_valid,
    input logic [rca_lsq_pkg::GRID_NUM_ROWS-1:0] row_valid,
    input logic credit_return,
    output logic [rca_lsq_pkg::ROW_W-1:0] next_row,
    output logic issue,
    output logic packet_done
);
    import rca_lsq_pkg::*;

    logic [GRID_NUM_ROWS-1:0] completed;
    logic [GRID_NUM_ROWS-1:0] pending;
    logic row_found;
    logic [CREDIT_W-1:0] credits;
    logic credit_avail;

    assign pending = row_valid & ~completed;
    assign row_found = |pending;

    // Lowest pending row wins
    always_comb begin
        next_row = '0;
        for (int i = GRID_NUM_ROWS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                next_row = ROW_W'(i);
            end
        end
    end

    assign credit_avail = (credits != '0);
    assign issue = head_valid && row_found && credit_avail;

    // Head drained, so release it
    assign packet_done = head_valid && !row_found;

    // Completion mask of the head packet
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            completed <= '0;
        end else if (packet_done) begin
            completed <= '0;
        end else if (issue) begin
            completed[next_row] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CREDIT_W'(LSU_CREDITS);
        end else begin
            case ({issue, credit_return})
                2'b10: credits <= credits - 1'b1; // Spend one
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* rtl/toggle_memory.sv */
module toggle_memory (
    input logic clk,
    input logic arst_n,
    input logic toggle,
    input rca_lsq_pkg::id_t toggle_id,
    input rca_lsq_pkg::id_t read_id,
    output logic read_data
);
    import rca_lsq_pkg::*;

    // One bit per packet id
    logic [MAX_IDS-1:0] id_bits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_bits <= '0;
        end else if (toggle) begin
            id_bits[toggle_id] <= ~id_bits[toggle_id];
        end
    end

    assign read_data = id_bits[read_id]; // Combinational lookup

endmodule

/* testbench/rca_lsq_golden.txt */
# P mask gap hold : packet row mask in hex, idle cycles before it, cycles of withheld returns
# R row addr data fn3 load store : one requesting row ; E addr data fn3 load store : issue
P 1 2 0
R 0 00001000 00000000 2 1 0
P a 0 0
R 1 00002004 00000000 0 1 0
R 3 0000200c a5a5a5a5 2 0 1
P f 0 0
R 0 00003000 00000001 2 0 1
R 1 00003004 00000002 2 0 1
R 2 00003008 00000000 4 1 0
R 3 0000300c 00000000 5 1 0
P 4 3 12
R 2 00004008 deadbeef 1 0 1
P 3 0 0
R 0 00005000 00000000 0 1 0
R 1 00005004 12345678 0 0 1
P 8 0 0
R 3 0000600c 00000000 2 1 0
P 5 0 0
R 0 00007000 cafef00d 2 0 1
R 2 00007008 00000000 4 1 0
P 2 0 0
R 1 00008004 0badc0de 1 0 1
E 00001000 00000000 2 1 0
E 00002004 00000000 0 1 0
E 0000200c a5a5a5a5 2 0 1
E 00003000 00000001 2 0 1
E 00003004 00000002 2 0 1
E 00003008 00000000 4 1 0
E 0000300c 00000000 5 1 0
E 00004008 deadbeef 1 0 1
E 00005000 00000000 0 1 0
E 00005004 12345678 0 0 1
E 0000600c 00000000 2 1 0
E 00007000 cafef00d 2 0 1
E 00007008 00000000 4 1 0
E 00008004 0badc0de 1 0 1

/* testbench/tb_rca_lsq.sv */
module tb_rca_lsq;
    import rca_lsq_pkg::*;

    localparam int MAX_PKTS = 16;
    localparam int MARGIN = 50;
    localparam int REQ_W = 2 * XLEN + FN3_W + 2;
    localparam string GOLDEN = "testbench/rca_lsq_golden.txt";

    logic clk;
    logic arst_n;
    logic [GRID_NUM_ROWS-1:0] new_request;
    logic [XLEN-1:0] addr [GRID_NUM_ROWS];
    logic [XLEN-1:0] data [GRID_NUM_ROWS];
    logic [FN3_W-1:0] fn3 [GRID_NUM_ROWS];
    logic [GRID_NUM_ROWS-1:0] load;
    logic [GRID_NUM_ROWS-1:0] store;
    logic fifo_full;
    logic lsu_new_request;
    logic [XLEN-1:0] lsu_addr;
    logic [XLEN-1:0] lsu_data;
    logic [FN3_W-1:0] lsu_fn3;
    logic lsu_load;
    logic lsu_store;
    logic lsu_lock;
    logic credit_return;

    int num_pkts;
    logic [GRID_NUM_ROWS-1:0] pkt_mask [MAX_PKTS];
    int pkt_gap [MAX_PKTS];
    int pkt_hold [MAX_PKTS];
    logic [XLEN-1:0] pkt_addr [MAX_PKTS][GRID_NUM_ROWS];
    logic [XLEN-1:0] pkt_data [MAX_PKTS][GRID_NUM_ROWS];
    logic [FN3_W-1:0] pkt_fn3 [MAX_PKTS][GRID_NUM_ROWS];
    logic [GRID_NUM_ROWS-1:0] pkt_load [MAX_PKTS];
    logic [GRID_NUM_ROWS-1:0] pkt_store [MAX_PKTS];
    logic [REQ_W-1:0] expected [$];

    int due [$]; // Return cycle of each credit held by the unit model
    int issued;
    int cycle;
    int limit;
    int hold_cnt;
    int seed;
    int mismatch_errors;
    int other_errors;
    bit seen_full;

    rca_lsq uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic load_golden();
        int fd;
        int row;
        string tag;
        string line;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        int f;
        int ld;
        int st;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("Cannot open %s", GOLDEN);
            other_errors++;
            return;
        end
        num_pkts = 0;
        while (!$feof(fd)) begin
            if ($fscanf(fd, "%s", tag) != 1) break;
            if (tag == "#") begin
                void'($fgets(line, fd)); // Column notes
            end else if (tag == "P") begin
                void'($fscanf(fd, "%h %d %d", pkt_mask[num_pkts], pkt_gap[num_pkts],
                              pkt_hold[num_pkts]));
                for (int r = 0; r < GRID_NUM_ROWS; r++) begin
                    pkt_addr[num_pkts][r] = 32'hee00_0000 | (num_pkts << 8) | r;
                    pkt_data[num_pkts][r] = 32'hffff_0000 | (num_pkts << 8) | r;
                    pkt_fn3[num_pkts][r] = 3'd7;
                end
                pkt_load[num_pkts] = '1;
                pkt_store[num_pkts] = '1;
                num_pkts++;
            end else if (tag == "R") begin
                void'($fscanf(fd, "%d %h %h %d %d %d", row, a, d, f, ld, st));
                pkt_addr[num_pkts-1][row] = a;
                pkt_data[num_pkts-1][row] = d;
                pkt_fn3[num_pkts-1][row] = FN3_W'(f);
                pkt_load[num_pkts-1][row] = ld[0];
                pkt_store[num_pkts-1][row] = st[0];
            end else if (tag == "E") begin
                void'($fscanf(fd, "%h %h %d %d %d", a, d, f, ld, st));
                expected.push_back({a, d, FN3_W'(f), ld[0], st[0]});
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_packets();
        for (int p = 0; p < num_pkts; p++) begin
            repeat (pkt_gap[p]) @(negedge clk);
            while (fifo_full) @(negedge clk); // Hold off while full
            new_request = pkt_mask[p];
            for (int r = 0; r < GRID_NUM_ROWS; r++) begin
                addr[r] = pkt_addr[p][r];
                data[r] = pkt_data[p][r];
                fn3[r] = pkt_fn3[p][r];
            end
            load = pkt_load[p];
            store = pkt_store[p];
            if (pkt_hold[p] > 0) hold_cnt = pkt_hold[p];
            @(negedge clk);
            new_request = '0; // One cycle per packet
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value mismatches, %0d other failures", mismatch_errors,
                 other_errors);
    endtask

    // Checker and credit-returning unit model
    always @(negedge clk) begin
        logic [REQ_W-1:0] actual;
        if (arst_n) begin
            cycle++;
            if (fifo_full) seen_full = 1'b1;
            if (lsu_new_request) begin
                actual = {lsu_addr, lsu_data, lsu_fn3, lsu_load, lsu_store};
                assert (issued < expected.size()) else begin
                    $display("Extra request issued beyond the expected list, addr %h", lsu_addr);
                    other_errors++;
                end
                if (issued < expected.size()) begin
                    assert (actual === expected[issued]) else begin
                        $display("FAIL issue_%0d expected %h actual %h", issued,
                                 expected[issued], actual);
                        mismatch_errors++;
                    end
                end
                issued++;
                assert (due.size() < LSU_CREDITS) else begin
                    $display("Request issued while the unit held every credit");
                    other_errors++;
                end
                assert (lsu_lock) else begin
                    $display("lsu_lock was low during an issue");
                    other_errors++;
                end
                due.push_back(cycle + int'($unsigned($random(seed)) % 4));
            end
            credit_return = 1'b0;
            if (hold_cnt > 0) begin
                hold_cnt--; // Returns withheld
            end else if (due.size() > 0 && due[0] <= cycle) begin
                credit_return = 1'b1;
                void'(due.pop_front());
            end
            if (cycle >= limit) begin
                $display("Timeout after %0d cycles, %0d of %0d requests were missing", cycle,
                         expected.size() - issued, expected.size());
                other_errors++;
                print_error_counts();
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        int lock_wait;
        arst_n = 1'b0;
        new_request = '0;
        for (int r = 0; r < GRID_NUM_ROWS; r++) begin
            addr[r] = '0;
            data[r] = '0;
            fn3[r] = '0;
        end
        load = '0;
        store = '0;
        credit_return = 1'b0;
        seed = 32'h243d;
        issued = 0;
        cycle = 0;
        hold_cnt = 0;
        mismatch_errors = 0;
        other_errors = 0;
        seen_full = 1'b0;
        load_golden();
        limit = 16 * expected.size() + MARGIN;
        repeat (10) @(negedge clk);
        assert (!lsu_new_request && !lsu_lock && !fifo_full) else begin
            $display("Outputs not idle in reset");
            other_errors++;
        end
        arst_n = 1'b1;
        drive_packets();
        wait (issued >= expected.size());
        lock_wait = 0;
        while (lsu_lock && lock_wait < 10) begin
            @(negedge clk);
            lock_wait++;
        end
        assert (!lsu_lock) else begin
            $display("lsu_lock stayed high after the last packet");
            other_errors++;
        end
        assert (seen_full) else begin
            $display("fifo_full never rose during back-to-back packets");
            other_errors++;
        end
        repeat (5) @(negedge clk); // Catch late repeats
        print_error_counts();
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
